/* hw/hdmi_video_pkg.sv */
package hdmi_video_pkg;

    // ************************************************************************
    // widths
    // ************************************************************************

    // one encoded TMDS symbol
    localparam int tmds_word_w = 10;

    // one colour channel of the pixel word
    localparam int color_w = 8;

    // signed running disparity, covers -8..+8 with headroom
    localparam int disparity_w = 5;

    // ************************************************************************
    // control tokens, sent while video is blanked
    // ************************************************************************

    // selected by the two control bits {c1, c0} = {vsync, hsync} on blue
    localparam logic [tmds_word_w-1:0] ctrl_token_00 = 10'b1101010100;
    localparam logic [tmds_word_w-1:0] ctrl_token_01 = 10'b0010101011;
    localparam logic [tmds_word_w-1:0] ctrl_token_10 = 10'b0101010100;
    localparam logic [tmds_word_w-1:0] ctrl_token_11 = 10'b1010101011;

    // ************************************************************************
    // colour channel positions in the 24-bit pixel
    // ************************************************************************

    // red in the top byte, blue in the bottom byte
    localparam int ch_red   = 2;
    localparam int ch_green = 1;
    localparam int ch_blue  = 0;

endpackage

/* hw/raster_timing.sv */
`timescale 1ns/1ps

module raster_timing #(
    parameter int H_ACTIVE   = 1280,
    parameter int H_FRONT    = 110,
    parameter int H_SYNC     = 40,
    parameter int H_BACK     = 220,
    parameter int V_ACTIVE   = 720,
    parameter int V_FRONT    = 5,
    parameter int V_SYNC     = 5,
    parameter int V_BACK     = 20,
    parameter int SYNC_DELAY = 2
) (
    input  logic        clk_pixel,
    input  logic        sys_rst,
    output logic [10:0] hcount,
    output logic [9:0]  vcount,
    output logic        new_frame,
    output logic        last_pixel,
    output logic        hsync_d,
    output logic        vsync_d,
    output logic        active_d
);

    // ************************************************************************
    // frame geometry
    // ************************************************************************

    // full line and full frame, blanking included
    localparam int htotal = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int vtotal = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // compare points sized to the counters
    localparam logic [10:0] h_last       = 11'(htotal - 1);
    localparam logic [9:0]  v_last       = 10'(vtotal - 1);
    localparam logic [10:0] h_act        = 11'(H_ACTIVE);
    localparam logic [9:0]  v_act        = 10'(V_ACTIVE);
    localparam logic [10:0] h_sync_start = 11'(H_ACTIVE + H_FRONT);
    localparam logic [10:0] h_sync_end   = 11'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [9:0]  v_sync_start = 10'(V_ACTIVE + V_FRONT);
    localparam logic [9:0]  v_sync_end   = 10'(V_ACTIVE + V_FRONT + V_SYNC);

    // undelayed decode of the current count
    logic hsync_raw;
    logic vsync_raw;
    logic active_raw;

    // alignment chains, index 0 is the youngest stage
    logic [SYNC_DELAY-1:0] hsync_pipe;
    logic [SYNC_DELAY-1:0] vsync_pipe;
    logic [SYNC_DELAY-1:0] active_pipe;

    // ************************************************************************
    // counters
    // ************************************************************************

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == h_last) begin
            // end of line, step the line counter
            hcount <= '0;
            if (vcount == v_last) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 10'd1;
            end
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // ************************************************************************
    // decode
    // ************************************************************************

    // positive sync pulses inside the blanking interval
    assign hsync_raw  = (hcount >= h_sync_start) && (hcount < h_sync_end);
    assign vsync_raw  = (vcount >= v_sync_start) && (vcount < v_sync_end);
    assign active_raw = (hcount < h_act) && (vcount < v_act);

    // counts sit at (0, 0) while held, so the pulse waits for release
    assign new_frame  = !sys_rst && (hcount == '0) && (vcount == '0);
    assign last_pixel = (hcount == h_last) && (vcount == v_last);

    // ************************************************************************
    // delay line
    // ************************************************************************

    // matches the latency of the external pixel source
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            // blank, no sync
            hsync_pipe  <= '0;
            vsync_pipe  <= '0;
            active_pipe <= '0;
        end else begin
            hsync_pipe[0]  <= hsync_raw;
            vsync_pipe[0]  <= vsync_raw;
            active_pipe[0] <= active_raw;
            for (int i = 1; i < SYNC_DELAY; i++) begin
                hsync_pipe[i]  <= hsync_pipe[i-1];
                vsync_pipe[i]  <= vsync_pipe[i-1];
                active_pipe[i] <= active_pipe[i-1];
            end
        end
    end

    // oldest stage drives the encoders
    assign hsync_d  = hsync_pipe[SYNC_DELAY-1];
    assign vsync_d  = vsync_pipe[SYNC_DELAY-1];
    assign active_d = active_pipe[SYNC_DELAY-1];

endmodule

/* hw/tmds_encoder.sv */
`timescale 1ns/1ps

module tmds_encoder (
    input  logic                                  clk_pixel,
    input  logic                                  sys_rst,
    input  logic [hdmi_video_pkg::color_w-1:0]    data,
    input  logic [1:0]                            control,
    input  logic                                  video_en,
    output logic [hdmi_video_pkg::tmds_word_w-1:0] tmds
);

    import hdmi_video_pkg::*;

    // ones in the input byte
    logic [3:0] ones_data;
    // xnor chain picked to cut transitions
    logic       use_xnor;
    // transition-minimised word, bit 8 set for xor
    logic [8:0] q_m;
    // ones in q_m[7:0]
    logic [3:0] ones_q;

    // ones minus zeros of q_m[7:0]
    logic signed [disparity_w-1:0] ones_q_s;
    logic signed [disparity_w-1:0] bal_q;
    // 2 when q_m[8] is set, else 0
    logic signed [disparity_w-1:0] xor_two;
    // 2 when q_m[8] is clear, else 0
    logic signed [disparity_w-1:0] xnor_two;

    // running disparity and its next value
    logic signed [disparity_w-1:0] disparity;
    logic signed [disparity_w-1:0] disparity_next;

    logic [tmds_word_w-1:0] video_word;
    logic [tmds_word_w-1:0] ctrl_word;

    // ************************************************************************
    // stage 1, transition minimising
    // ************************************************************************

    always_comb begin
        ones_data = '0;
        for (int i = 0; i < color_w; i++) begin
            ones_data = ones_data + 4'(data[i]);
        end
    end

    // tie at four ones broken by bit 0
    assign use_xnor = (ones_data > 4'd4) || ((ones_data == 4'd4) && !data[0]);

    always_comb begin
        q_m[0] = data[0];
        for (int i = 1; i < color_w; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8] = !use_xnor;
    end

    always_comb begin
        ones_q = '0;
        for (int i = 0; i < color_w; i++) begin
            ones_q = ones_q + 4'(q_m[i]);
        end
    end

    // ************************************************************************
    // stage 2, dc balancing
    // ************************************************************************

    // 2*ones - 8, wraps cleanly since the result is within -8..+8
    assign ones_q_s = disparity_w'(ones_q);
    assign bal_q    = ones_q_s + ones_q_s - disparity_w'(8);
    assign xor_two  = q_m[8] ? disparity_w'(2) : '0;
    assign xnor_two = q_m[8] ? '0 : disparity_w'(2);

    always_comb begin
        if ((disparity == 0) || (bal_q == 0)) begin
            // no bias either way, bit 9 marks the xnor case
            video_word = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                disparity_next = disparity + bal_q;
            end else begin
                disparity_next = disparity - bal_q;
            end
        end else if (((disparity > 0) && (bal_q > 0)) ||
                     ((disparity < 0) && (bal_q < 0))) begin
            // same sign as the running total, so invert
            video_word     = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity + xor_two - bal_q;
        end else begin
            video_word     = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity - xnor_two + bal_q;
        end
    end

    // ************************************************************************
    // control tokens and output register
    // ************************************************************************

    always_comb begin
        case (control)
            2'b00:   ctrl_word = ctrl_token_00;
            2'b01:   ctrl_word = ctrl_token_01;
            2'b10:   ctrl_word = ctrl_token_10;
            default: ctrl_word = ctrl_token_11;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            tmds      <= ctrl_token_00;
            disparity <= '0;
        end else if (video_en) begin
            tmds      <= video_word;
            disparity <= disparity_next;
        end else begin
            // blanking restarts the dc count
            tmds      <= ctrl_word;
            disparity <= '0;
        end
    end

endmodule

/* hw/hdmi_video_top.sv */
`timescale 1ns/1ps

module hdmi_video_top #(
    parameter int H_ACTIVE   = 1280,
    parameter int H_FRONT    = 110,
    parameter int H_SYNC     = 40,
    parameter int H_BACK     = 220,
    parameter int V_ACTIVE   = 720,
    parameter int V_FRONT    = 5,
    parameter int V_SYNC     = 5,
    parameter int V_BACK     = 20,
    parameter int SYNC_DELAY = 2
) (
    input  logic                                   clk_pixel,
    input  logic                                   sys_rst,
    input  logic [23:0]                            pixel_rgb,
    output logic [10:0]                            hcount,
    output logic [9:0]                             vcount,
    output logic                                   new_frame,
    output logic                                   last_pixel,
    output logic [hdmi_video_pkg::tmds_word_w-1:0] tmds_red,
    output logic [hdmi_video_pkg::tmds_word_w-1:0] tmds_green,
    output logic [hdmi_video_pkg::tmds_word_w-1:0] tmds_blue
);

    import hdmi_video_pkg::*;

    // control path, aligned to pixel_rgb
    logic hsync_d;
    logic vsync_d;
    logic active_d;

    // colour channels
    logic [color_w-1:0] red;
    logic [color_w-1:0] green;
    logic [color_w-1:0] blue;

    assign red   = pixel_rgb[ch_red*color_w +: color_w];
    assign green = pixel_rgb[ch_green*color_w +: color_w];
    assign blue  = pixel_rgb[ch_blue*color_w +: color_w];

    // ************************************************************************
    // raster
    // ************************************************************************

    raster_timing #(
        .H_ACTIVE   (H_ACTIVE),
        .H_FRONT    (H_FRONT),
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .V_ACTIVE   (V_ACTIVE),
        .V_FRONT    (V_FRONT),
        .V_SYNC     (V_SYNC),
        .V_BACK     (V_BACK),
        .SYNC_DELAY (SYNC_DELAY)
    ) raster_timing_i (
        .clk_pixel  (clk_pixel),
        .sys_rst    (sys_rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .new_frame  (new_frame),
        .last_pixel (last_pixel),
        .hsync_d    (hsync_d),
        .vsync_d    (vsync_d),
        .active_d   (active_d)
    );

    // ************************************************************************
    // encoders, sync rides on blue only
    // ************************************************************************

    tmds_encoder tmds_red_i (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .data      (red),
        .control   (2'b00),
        .video_en  (active_d),
        .tmds      (tmds_red)
    );

    tmds_encoder tmds_green_i (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .data      (green),
        .control   (2'b00),
        .video_en  (active_d),
        .tmds      (tmds_green)
    );

    tmds_encoder tmds_blue_i (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .data      (blue),
        .control   ({vsync_d, hsync_d}),
        .video_en  (active_d),
        .tmds      (tmds_blue)
    );

endmodule

/* tb/hdmi_video_asserts.sv */
`timescale 1ns/1ps

module hdmi_video_asserts (
    input logic clk_pixel,
    input logic sys_rst,
    input logic new_frame,
    input logic hsync_d,
    input logic vsync_d,
    input logic active_d
);

    // failed assertions so far, read by the testbench top
    int assert_errors;

    initial begin
        assert_errors = 0;
    end

    // frame start is a single-cycle pulse
    new_frame_single: assert property (
        @(posedge clk_pixel) disable iff (sys_rst) new_frame |=> !new_frame
    ) else begin
        $error("new_frame stayed high for more than one cycle");
        assert_errors++;
    end

    // no sync pulse inside the delayed picture
    hsync_outside_active: assert property (
        @(posedge clk_pixel) disable iff (sys_rst) !(active_d && hsync_d)
    ) else begin
        $error("hsync_d overlaps active_d");
        assert_errors++;
    end

    vsync_outside_active: assert property (
        @(posedge clk_pixel) disable iff (sys_rst) !(active_d && vsync_d)
    ) else begin
        $error("vsync_d overlaps active_d");
        assert_errors++;
    end

endmodule

bind raster_timing hdmi_video_asserts asserts_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .new_frame (new_frame),
    .hsync_d   (hsync_d),
    .vsync_d   (vsync_d),
    .active_d  (active_d)
);

/* tb/hdmi_video_checker.sv */
`timescale 1ns/1ps

module hdmi_video_checker #(
    parameter int H_ACTIVE = 16,
    parameter int H_FRONT  = 2,
    parameter int H_SYNC   = 3,
    parameter int H_BACK   = 3,
    parameter int V_ACTIVE = 6,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 1
) (
    input  logic                                   clk_pixel,
    input  logic                                   sys_rst,
    input  logic [23:0]                            pixel_rgb,
    input  logic [10:0]                            hcount,
    input  logic [9:0]                             vcount,
    input  logic                                   new_frame,
    input  logic                                   last_pixel,
    input  logic [hdmi_video_pkg::tmds_word_w-1:0] tmds_red,
    input  logic [hdmi_video_pkg::tmds_word_w-1:0] tmds_green,
    input  logic [hdmi_video_pkg::tmds_word_w-1:0] tmds_blue,
    input  logic [63:0]                            test_name,
    input  logic                                   test_end,
    output int                                     pass_count,
    output int                                     fail_count,
    output int                                     err_total
);

    import hdmi_video_pkg::*;

    localparam int htotal = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int vtotal = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int hs_start = H_ACTIVE + H_FRONT;
    localparam int vs_start = V_ACTIVE + V_FRONT;

    // model raster position of the current cycle
    int h_m;
    int v_m;
    logic model_valid;
    // {vsync, hsync, active}, p2 is the older stage
    logic [2:0] p1;
    logic [2:0] p2;
    // per channel, index 0 red, 2 blue
    int disp [3];
    logic [tmds_word_w-1:0] exp_w [3];
    logic exp_video;
    logic [23:0] exp_rgb;
    int test_errs;

    initial begin
        model_valid = 1'b0;
        pass_count = 0;
        fail_count = 0;
        err_total = 0;
        test_errs = 0;
    end

    // DVI 1.0 encoding, stage 1 then dc balance
    function automatic void encode_ref(input logic [7:0] d, input int cnt_in,
                                       output logic [9:0] q, output int cnt_out);
        int n1;
        int diff;
        logic xnor_mode;
        logic [8:0] qm;
        n1 = $countones(d);
        xnor_mode = (n1 > 4) || (n1 == 4 && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = xnor_mode ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !xnor_mode;
        // ones minus zeros of the low byte
        diff = 2 * $countones(qm[7:0]) - 8;
        if (cnt_in == 0 || diff == 0) begin
            q = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            cnt_out = qm[8] ? cnt_in + diff : cnt_in - diff;
        end else if ((cnt_in > 0 && diff > 0) || (cnt_in < 0 && diff < 0)) begin
            q = {1'b1, qm[8], ~qm[7:0]};
            cnt_out = cnt_in + (qm[8] ? 2 : 0) - diff;
        end else begin
            q = {1'b0, qm[8], qm[7:0]};
            cnt_out = cnt_in - (qm[8] ? 0 : 2) + diff;
        end
    endfunction

    // receiver side, undo inversion then the xor/xnor chain
    function automatic logic [7:0] decode_word(input logic [9:0] w);
        logic [7:0] v;
        logic [7:0] d;
        v = w[9] ? ~w[7:0] : w[7:0];
        d[0] = v[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = w[8] ? (v[i] ^ v[i-1]) : ~(v[i] ^ v[i-1]);
        end
        return d;
    endfunction

    function automatic logic [9:0] token_for(input logic [1:0] c);
        case (c)
            2'b00:   return ctrl_token_00;
            2'b01:   return ctrl_token_01;
            2'b10:   return ctrl_token_10;
            default: return ctrl_token_11;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expv,
                               input logic [31:0] actv);
        if (expv !== actv) begin
            test_errs++;
            err_total++;
            $display("** Error %0s: %0s expected %0h actual %0h",
                     test_name, what, expv, actv);
        end
    endtask

    // ************************************************************************
    // compare, then step the model one cycle
    // ************************************************************************

    always @(posedge clk_pixel) begin
        logic [tmds_word_w-1:0] w;
        int d;
        if (model_valid) begin
            check_value("hcount", h_m, hcount);
            check_value("vcount", v_m, vcount);
            check_value("new_frame", 32'(h_m == 0 && v_m == 0 && !sys_rst), new_frame);
            check_value("last_pixel", 32'(h_m == htotal - 1 && v_m == vtotal - 1), last_pixel);
            check_value("tmds_red", exp_w[0], tmds_red);
            check_value("tmds_green", exp_w[1], tmds_green);
            check_value("tmds_blue", exp_w[2], tmds_blue);
            if (exp_video) begin
                check_value("red decode", exp_rgb[23:16], decode_word(tmds_red));
                check_value("green decode", exp_rgb[15:8], decode_word(tmds_green));
                check_value("blue decode", exp_rgb[7:0], decode_word(tmds_blue));
            end
        end
        if (test_end) begin
            $display("test %0s: %0d mismatches, %0s", test_name, test_errs,
                     (test_errs == 0) ? "passed" : "failed");
            if (test_errs == 0) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            test_errs = 0;
        end
        if (sys_rst) begin
            h_m = 0;
            v_m = 0;
            p1 = '0;
            p2 = '0;
            exp_video = 1'b0;
            for (int i = 0; i < 3; i++) begin
                disp[i] = 0;
                exp_w[i] = ctrl_token_00;
            end
            model_valid = 1'b1;
        end else begin
            if (p2[0]) begin
                // picture, encode the byte present now
                for (int i = 0; i < 3; i++) begin
                    encode_ref(pixel_rgb[(2-i)*8 +: 8], disp[i], w, d);
                    exp_w[i] = w;
                    disp[i] = d;
                end
                exp_video = 1'b1;
                exp_rgb = pixel_rgb;
            end else begin
                // blanking, sync rides on blue
                exp_w[0] = ctrl_token_00;
                exp_w[1] = ctrl_token_00;
                exp_w[2] = token_for(p2[2:1]);
                for (int i = 0; i < 3; i++) begin
                    disp[i] = 0;
                end
                exp_video = 1'b0;
            end
            p2 = p1;
            p1[2] = (v_m >= vs_start) && (v_m < vs_start + V_SYNC);
            p1[1] = (h_m >= hs_start) && (h_m < hs_start + H_SYNC);
            p1[0] = (h_m < H_ACTIVE) && (v_m < V_ACTIVE);
            if (h_m == htotal - 1) begin
                h_m = 0;
                v_m = (v_m == vtotal - 1) ? 0 : v_m + 1;
            end else begin
                h_m++;
            end
        end
    end

endmodule

/* tb/hdmi_video_tb.sv */
`timescale 1ns/1ps

module hdmi_video_tb;

    // ************************************************************************
    // small raster, 24 x 10 = 240 cycles per frame
    // ************************************************************************

    localparam int h_active = 16;
    localparam int h_front = 2;
    localparam int h_sync = 3;
    localparam int h_back = 3;
    localparam int v_active = 6;
    localparam int v_front = 1;
    localparam int v_sync = 2;
    localparam int v_back = 1;
    localparam int frame_cycles = (h_active + h_front + h_sync + h_back) *
                                  (v_active + v_front + v_sync + v_back);
    localparam int clk_period = 20;
    localparam int reset_cycles = 16;

    // pattern kinds
    localparam int k_const = 0;
    localparam int k_ramp = 1;
    localparam int k_random = 2;

    // test table, one row per test
    localparam int n_tests = 6;
    localparam logic [63:0] t_name [n_tests] =
        '{"black", "white", "grey10", "mixed", "ramp", "random"};
    localparam int t_kind [n_tests] =
        '{k_const, k_const, k_const, k_const, k_ramp, k_random};
    localparam logic [23:0] t_base [n_tests] =
        '{24'h000000, 24'hffffff, 24'h101010, 24'h3c5aa5, 24'h204060, 24'h000000};
    localparam int t_frames [n_tests] = '{1, 1, 1, 1, 2, 3};

    logic        clk_pixel;
    logic        sys_rst;
    logic [23:0] pixel_rgb;
    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        new_frame;
    logic        last_pixel;
    logic [9:0]  tmds_red;
    logic [9:0]  tmds_green;
    logic [9:0]  tmds_blue;

    // current pattern and test bookkeeping
    int          cur_kind;
    logic [23:0] cur_base;
    logic [63:0] test_name;
    logic        test_end;
    integer      seed;
    int          pass_count;
    int          fail_count;
    int          err_total;

    // counts one cycle back, the drive adds the second cycle
    logic [10:0] h_q;
    logic [9:0]  v_q;

    hdmi_video_top #(
        .H_ACTIVE (h_active),
        .H_FRONT  (h_front),
        .H_SYNC   (h_sync),
        .H_BACK   (h_back),
        .V_ACTIVE (v_active),
        .V_FRONT  (v_front),
        .V_SYNC   (v_sync),
        .V_BACK   (v_back)
    ) hdmi_video_top_i (
        .clk_pixel  (clk_pixel),
        .sys_rst    (sys_rst),
        .pixel_rgb  (pixel_rgb),
        .hcount     (hcount),
        .vcount     (vcount),
        .new_frame  (new_frame),
        .last_pixel (last_pixel),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue)
    );

    hdmi_video_checker #(
        .H_ACTIVE (h_active),
        .H_FRONT  (h_front),
        .H_SYNC   (h_sync),
        .H_BACK   (h_back),
        .V_ACTIVE (v_active),
        .V_FRONT  (v_front),
        .V_SYNC   (v_sync),
        .V_BACK   (v_back)
    ) checker_i (
        .clk_pixel  (clk_pixel),
        .sys_rst    (sys_rst),
        .pixel_rgb  (pixel_rgb),
        .hcount     (hcount),
        .vcount     (vcount),
        .new_frame  (new_frame),
        .last_pixel (last_pixel),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue),
        .test_name  (test_name),
        .test_end   (test_end),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .err_total  (err_total)
    );

    always #(clk_period / 2) clk_pixel = ~clk_pixel;

    // gradient that moves in all three channels
    function automatic logic [23:0] ramp_color(input logic [10:0] h, input logic [9:0] v);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = 8'(h * 16) ^ v[7:0];
        g = 8'(v * 40) + h[7:0];
        b = h[7:0] + 8'(v * 16) + 8'h05;
        return {r, g, b};
    endfunction

    // ************************************************************************
    // pixel source, two cycles behind the counts
    // ************************************************************************

    always @(posedge clk_pixel) begin
        h_q <= hcount;
        v_q <= vcount;
        case (cur_kind)
            k_ramp:   pixel_rgb <= cur_base + ramp_color(h_q, v_q);
            k_random: pixel_rgb <= 24'($random(seed));
            default:  pixel_rgb <= cur_base;
        endcase
    end

    // ************************************************************************
    // test sequence
    // ************************************************************************

    initial begin
        int frames;
        clk_pixel = 1'b0;
        sys_rst = 1'b1;
        pixel_rgb = '0;
        h_q = '0;
        v_q = '0;
        seed = 32'hac66;
        cur_kind = k_const;
        cur_base = '0;
        test_name = t_name[0];
        test_end = 1'b0;
        repeat (reset_cycles) @(posedge clk_pixel);
        sys_rst <= 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            @(posedge clk_pixel);
            test_end <= 1'b0;
            test_name <= t_name[i];
            cur_kind <= t_kind[i];
            cur_base <= t_base[i];
            frames = 0;
            // whole frames, counted on the frame pulse
            while (frames < t_frames[i]) begin
                @(posedge clk_pixel);
                if (new_frame) begin
                    frames++;
                end
            end
            test_end <= 1'b1;
        end
        @(posedge clk_pixel);
        test_end <= 1'b0;
        repeat (2) @(posedge clk_pixel);
        $display("tests passed %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 pass_count, fail_count, err_total,
                 hdmi_video_top_i.raster_timing_i.asserts_i.assert_errors);
        if (fail_count == 0 && err_total == 0 && pass_count == n_tests &&
            hdmi_video_top_i.raster_timing_i.asserts_i.assert_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog, all frames plus two spare frames plus reset
    initial begin
        int total;
        total = 0;
        for (int i = 0; i < n_tests; i++) begin
            total += t_frames[i];
        end
        #((total + 2) * frame_cycles * clk_period + reset_cycles * clk_period);
        $display("timeout: the tests did not finish within %0d frames", total + 2);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* hdmi_video.f */
hw/hdmi_video_pkg.sv
hw/raster_timing.sv
hw/tmds_encoder.sv
hw/hdmi_video_top.sv
tb/hdmi_video_asserts.sv
tb/hdmi_video_checker.sv
tb/hdmi_video_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hdmi_video_tb -f hdmi_video.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vhdmi_video_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
